//--- common/soc_pkg.sv
// Address map, bus structs and boot image; all accesses are whole 64-bit words with byte enables
`default_nettype none

package soc_pkg;

  // ------------------------------------------------------------------------
  // Widths and address map
  // ------------------------------------------------------------------------
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 64;
  localparam int unsigned BeWidth    = DataWidth / 8;
  localparam int unsigned ByteOffset = $clog2(BeWidth);

  localparam logic [AddrWidth-1:0] RomBase     = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] RomLength   = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] ClintBase   = 32'h0200_0000;
  localparam logic [AddrWidth-1:0] ClintLength = 32'h0000_C000;
  localparam logic [AddrWidth-1:0] RamBase     = 32'h8000_0000;
  localparam int unsigned          RamWords    = 256;
  localparam logic [AddrWidth-1:0] RamLength   = AddrWidth'(RamWords * BeWidth);
  localparam int unsigned          RamIdxWidth = $clog2(RamWords);

  // Timer register offsets inside the CLINT window
  localparam int unsigned              ClintOffWidth  = $clog2(ClintLength);
  localparam logic [ClintOffWidth-1:0] MsipOffset     = 16'h0000;
  localparam logic [ClintOffWidth-1:0] MtimecmpOffset = 16'h4000;
  localparam logic [ClintOffWidth-1:0] MtimeOffset    = 16'hBFF8;

  // Boot image, the rest of the ROM window reads as zero
  localparam int unsigned RomWords    = 8;
  localparam int unsigned RomIdxWidth = $clog2(RomLength / BeWidth);
  localparam int unsigned RomSelWidth = $clog2(RomWords);
  localparam logic [DataWidth-1:0] RomImage [RomWords] = '{
    64'h0010_029b_0000_0297, 64'h0202_8293_01f2_9293, 64'hf140_2573_0000_0597,
    64'h0005_8593_0002_8067, 64'h1050_0073_ffdf_f06f, 64'h0000_0000_0000_0013,
    64'hdead_beef_cafe_f00d, 64'h0123_4567_89ab_cdef
  };

  // Debug request window after reset, in clk_i cycles
  localparam int unsigned DebugDelayCycles = 32;
  localparam int unsigned DebugCntWidth    = $clog2(DebugDelayCycles + 1);

  // Bus masters
  localparam int unsigned NumMasters  = 2;
  localparam int unsigned MstIdxWidth = $clog2(NumMasters);
  localparam int unsigned HostIdx     = 0;
  localparam int unsigned DebugIdx    = 1;

  // ------------------------------------------------------------------------
  // Bus types
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                 gnt;
    logic                 r_valid;
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

  typedef enum logic [1:0] {ROM, RAM, CLINT, NONE} slave_sel_e;

  // Byte lanes of new_data replace old_data where be is set
  function automatic logic [DataWidth-1:0] be_merge(input logic [DataWidth-1:0] old_data,
                                                    input logic [DataWidth-1:0] new_data,
                                                    input logic [BeWidth-1:0]   be);
    logic [DataWidth-1:0] merged;
    merged = old_data;
    for (int i = 0; i < BeWidth; i++) begin
      if (be[i]) begin
        merged[i*8 +: 8] = new_data[i*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

//--- rtl/bus_arbiter.sv
// Fixed priority, highest master index wins; one grant per cycle, responses follow one cycle later
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  soc_pkg::bus_req_t [soc_pkg::NumMasters-1:0] mst_req_i,
  output soc_pkg::bus_rsp_t [soc_pkg::NumMasters-1:0] mst_rsp_o,
  output soc_pkg::bus_req_t                           slv_req_o,
  input  logic                                        slv_rvalid_i,
  input  logic [soc_pkg::DataWidth-1:0]               slv_rdata_i,
  input  logic                                        slv_err_i
);

  logic                            sel_valid;
  logic [soc_pkg::MstIdxWidth-1:0] sel_idx;
  logic [soc_pkg::MstIdxWidth-1:0] owner_q;

  // Later indexes override, so the debug port beats the host
  always_comb begin
    sel_valid = 1'b0;
    sel_idx   = '0;
    for (int i = 0; i < soc_pkg::NumMasters; i++) begin
      if (mst_req_i[i].req) begin
        sel_valid = 1'b1;
        sel_idx   = soc_pkg::MstIdxWidth'(i);
      end
    end
  end

  always_comb begin
    slv_req_o     = mst_req_i[sel_idx];
    slv_req_o.req = sel_valid;
  end

  // Owner of the access whose response arrives next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q <= '0;
    end else if (sel_valid) begin
      owner_q <= sel_idx;
    end
  end

  for (genvar i = 0; i < soc_pkg::NumMasters; i++) begin : gen_rsp
    logic owns;
    assign owns                 = slv_rvalid_i && (owner_q == soc_pkg::MstIdxWidth'(i));
    assign mst_rsp_o[i].gnt     = sel_valid && (sel_idx == soc_pkg::MstIdxWidth'(i));
    assign mst_rsp_o[i].r_valid = owns;
    assign mst_rsp_o[i].rdata   = owns ? slv_rdata_i : '0;
    assign mst_rsp_o[i].err     = owns && slv_err_i;
  end

endmodule

`default_nettype wire

//--- rtl/addr_decoder.sv
// Routes a granted access to one slave; unmapped addresses and ROM writes answer err with zero data
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  soc_pkg::bus_req_t             req_i,
  output logic                          rom_req_o,
  output logic                          ram_req_o,
  output logic                          clint_req_o,
  input  logic [soc_pkg::DataWidth-1:0] rom_rdata_i,
  input  logic [soc_pkg::DataWidth-1:0] ram_rdata_i,
  input  logic [soc_pkg::DataWidth-1:0] clint_rdata_i,
  output logic                          rvalid_o,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic                          err_o
);

  soc_pkg::slave_sel_e sel;
  soc_pkg::slave_sel_e sel_q;
  logic                err;
  logic                err_q;
  logic                valid_q;

  always_comb begin
    if (req_i.addr >= soc_pkg::RomBase && req_i.addr < soc_pkg::RomBase + soc_pkg::RomLength) begin
      sel = soc_pkg::ROM;
    end else if (req_i.addr >= soc_pkg::RamBase &&
                 req_i.addr < soc_pkg::RamBase + soc_pkg::RamLength) begin
      sel = soc_pkg::RAM;
    end else if (req_i.addr >= soc_pkg::ClintBase &&
                 req_i.addr < soc_pkg::ClintBase + soc_pkg::ClintLength) begin
      sel = soc_pkg::CLINT;
    end else begin
      sel = soc_pkg::NONE;
    end
  end

  assign err = req_i.req && ((sel == soc_pkg::NONE) || (sel == soc_pkg::ROM && req_i.we));

  assign rom_req_o   = req_i.req && !err && (sel == soc_pkg::ROM);
  assign ram_req_o   = req_i.req && !err && (sel == soc_pkg::RAM);
  assign clint_req_o = req_i.req && !err && (sel == soc_pkg::CLINT);

  // Writes and errors return no data, so they select NONE
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      sel_q   <= soc_pkg::NONE;
    end else begin
      valid_q <= req_i.req;
      err_q   <= err;
      sel_q   <= (req_i.req && !err && !req_i.we) ? sel : soc_pkg::NONE;
    end
  end

  assign rvalid_o = valid_q;
  assign err_o    = err_q;

  always_comb begin
    unique case (sel_q)
      soc_pkg::ROM:   rdata_o = rom_rdata_i;
      soc_pkg::RAM:   rdata_o = ram_rdata_i;
      soc_pkg::CLINT: rdata_o = clint_rdata_i;
      default:        rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/boot_rom.sv
// Boot image is fixed at elaboration; words past the image inside the ROM window read as zero
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  logic                          clk_i,
  input  logic                          req_i,
  input  logic [soc_pkg::AddrWidth-1:0] addr_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o
);

  logic [soc_pkg::RomIdxWidth-1:0] idx;

  assign idx = addr_i[soc_pkg::ByteOffset +: soc_pkg::RomIdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (idx < soc_pkg::RomWords) begin
        rdata_o <= soc_pkg::RomImage[idx[soc_pkg::RomSelWidth-1:0]];
      end else begin
        rdata_o <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/sram.sv
// Word RAM with no initial contents; address bits above the RAM size are ignored
`timescale 1ns/1ps
`default_nettype none

module sram (
  input  logic                          clk_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [soc_pkg::AddrWidth-1:0] addr_i,
  input  logic [soc_pkg::BeWidth-1:0]   be_i,
  input  logic [soc_pkg::DataWidth-1:0] wdata_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o
);

  logic [soc_pkg::DataWidth-1:0]   mem [soc_pkg::RamWords];
  logic [soc_pkg::RamIdxWidth-1:0] idx;

  // Byte address to word index
  assign idx = addr_i[soc_pkg::ByteOffset +: soc_pkg::RamIdxWidth];

  // ------------------------------------------------------------------------
  // Single port, write or read per access
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[idx] <= soc_pkg::be_merge(mem[idx], wdata_i, be_i);
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/clint_timer.sv
// Single hart timer; rtc_i must be a one-cycle pulse already synchronous to clk_i
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [soc_pkg::AddrWidth-1:0] addr_i,
  input  logic [soc_pkg::BeWidth-1:0]   be_i,
  input  logic [soc_pkg::DataWidth-1:0] wdata_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  input  logic                          rtc_i,
  output logic                          timer_irq_o,
  output logic                          ipi_o
);

  logic [soc_pkg::ClintOffWidth-1:0] off;
  logic                              wr;
  logic                              msip_q;
  logic [soc_pkg::DataWidth-1:0]     mtime_q;
  logic [soc_pkg::DataWidth-1:0]     mtimecmp_q;
  logic [soc_pkg::DataWidth-1:0]     rd_val;

  // Word-aligned offset inside the CLINT window
  assign off = {addr_i[soc_pkg::ClintOffWidth-1:soc_pkg::ByteOffset],
                {soc_pkg::ByteOffset{1'b0}}};
  assign wr  = req_i && we_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msip_q     <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      if (wr && off == soc_pkg::MsipOffset && be_i[0]) begin
        msip_q <= wdata_i[0];
      end
      if (wr && off == soc_pkg::MtimecmpOffset) begin
        mtimecmp_q <= soc_pkg::be_merge(mtimecmp_q, wdata_i, be_i);
      end
      // Software write wins over the tick
      if (wr && off == soc_pkg::MtimeOffset) begin
        mtime_q <= soc_pkg::be_merge(mtime_q, wdata_i, be_i);
      end else if (rtc_i) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  always_comb begin
    unique case (off)
      soc_pkg::MsipOffset:     rd_val = {{(soc_pkg::DataWidth-1){1'b0}}, msip_q};
      soc_pkg::MtimecmpOffset: rd_val = mtimecmp_q;
      soc_pkg::MtimeOffset:    rd_val = mtime_q;
      default:                 rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= rd_val;
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

//--- rtl/debug_req_gate.sv
// Debug requests are blocked for DebugDelayCycles clocks after reset so boot code can run first
`timescale 1ns/1ps
`default_nettype none

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  logic [soc_pkg::DebugCntWidth-1:0] cnt_q;

  // Counts down once and then parks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= soc_pkg::DebugCntWidth'(soc_pkg::DebugDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) && debug_en_i && debug_req_i;

endmodule

`default_nettype wire

//--- rtl/soc_harness.sv
// Two masters on one bus; masters must hold a request stable until they see gnt
`timescale 1ns/1ps
`default_nettype none

module soc_harness (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rtc_i,
  input  soc_pkg::bus_req_t host_req_i,
  input  soc_pkg::bus_req_t dbg_req_i,
  output soc_pkg::bus_rsp_t host_rsp_o,
  output soc_pkg::bus_rsp_t dbg_rsp_o,
  input  logic              debug_req_i,
  input  logic              debug_en_i,
  output logic              debug_req_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  soc_pkg::bus_req_t [soc_pkg::NumMasters-1:0] mst_req;
  soc_pkg::bus_rsp_t [soc_pkg::NumMasters-1:0] mst_rsp;
  soc_pkg::bus_req_t                           slv_req;
  logic                                        slv_rvalid;
  logic [soc_pkg::DataWidth-1:0]               slv_rdata;
  logic                                        slv_err;
  logic                                        rom_req;
  logic                                        ram_req;
  logic                                        clint_req;
  logic [soc_pkg::DataWidth-1:0]               rom_rdata;
  logic [soc_pkg::DataWidth-1:0]               ram_rdata;
  logic [soc_pkg::DataWidth-1:0]               clint_rdata;

  assign mst_req[soc_pkg::HostIdx]  = host_req_i;
  assign mst_req[soc_pkg::DebugIdx] = dbg_req_i;
  assign host_rsp_o = mst_rsp[soc_pkg::HostIdx];
  assign dbg_rsp_o  = mst_rsp[soc_pkg::DebugIdx];

  // ------------------------------------------------------------------------
  // Interconnect
  // ------------------------------------------------------------------------
  bus_arbiter i_bus_arbiter (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .mst_req_i    ( mst_req    ),
    .mst_rsp_o    ( mst_rsp    ),
    .slv_req_o    ( slv_req    ),
    .slv_rvalid_i ( slv_rvalid ),
    .slv_rdata_i  ( slv_rdata  ),
    .slv_err_i    ( slv_err    )
  );

  addr_decoder i_addr_decoder (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .req_i         ( slv_req     ),
    .rom_req_o     ( rom_req     ),
    .ram_req_o     ( ram_req     ),
    .clint_req_o   ( clint_req   ),
    .rom_rdata_i   ( rom_rdata   ),
    .ram_rdata_i   ( ram_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .rvalid_o      ( slv_rvalid  ),
    .rdata_o       ( slv_rdata   ),
    .err_o         ( slv_err     )
  );

  // ------------------------------------------------------------------------
  // Slaves
  // ------------------------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i        ),
    .req_i   ( rom_req      ),
    .addr_i  ( slv_req.addr ),
    .rdata_o ( rom_rdata    )
  );

  sram i_sram (
    .clk_i   ( clk_i         ),
    .req_i   ( ram_req       ),
    .we_i    ( slv_req.we    ),
    .addr_i  ( slv_req.addr  ),
    .be_i    ( slv_req.be    ),
    .wdata_i ( slv_req.wdata ),
    .rdata_o ( ram_rdata     )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .req_i       ( clint_req     ),
    .we_i        ( slv_req.we    ),
    .addr_i      ( slv_req.addr  ),
    .be_i        ( slv_req.be    ),
    .wdata_i     ( slv_req.wdata ),
    .rdata_o     ( clint_rdata   ),
    .rtc_i       ( rtc_i         ),
    .timer_irq_o ( timer_irq_o   ),
    .ipi_o       ( ipi_o         )
  );

  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

//--- tests/soc_harness_sva.sv
// Bound to bus_arbiter; properties are disabled while rst_ni is low
`timescale 1ns/1ps
`default_nettype none

module soc_harness_sva (
  input logic                                        clk_i,
  input logic                                        rst_ni,
  input soc_pkg::bus_rsp_t [soc_pkg::NumMasters-1:0] mst_rsp_i
);

  logic [soc_pkg::NumMasters-1:0] gnt;
  logic [soc_pkg::NumMasters-1:0] rvalid;

  for (genvar i = 0; i < soc_pkg::NumMasters; i++) begin : gen_master
    assign gnt[i]    = mst_rsp_i[i].gnt;
    assign rvalid[i] = mst_rsp_i[i].r_valid;

    // Response belongs to the granted master only
    grant_then_response: assert property (@(posedge clk_i) disable iff (!rst_ni)
      gnt[i] |=> rvalid[i] && $onehot(rvalid))
      else $error("grant to master %0d had no response one cycle later", i);
  end

  one_grant: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt))
    else $error("more than one grant in one cycle");

endmodule

bind bus_arbiter soc_harness_sva i_soc_harness_sva (
  .clk_i     ( clk_i     ),
  .rst_ni    ( rst_ni    ),
  .mst_rsp_i ( mst_rsp_o )
);

`default_nettype wire

//--- tests/tb_soc_harness.sv
// Directed tests drive on the falling edge and sample there or 1 ns later; RAM data is random
`timescale 1ns/1ps
`default_nettype none

module tb_soc_harness;

  localparam int unsigned ClkPeriod      = 40;
  localparam int unsigned ResetCycles    = 16;
  localparam int unsigned WatchdogCycles = 2000;
  localparam int unsigned GntTimeout     = 8;
  localparam int unsigned RamTrials      = 16;

  logic              clk_i;
  logic              rst_ni;
  logic              rtc_i;
  soc_pkg::bus_req_t host_req;
  soc_pkg::bus_req_t dbg_req;
  soc_pkg::bus_rsp_t host_rsp;
  soc_pkg::bus_rsp_t dbg_rsp;
  logic              debug_req_i;
  logic              debug_en_i;
  logic              debug_req_o;
  logic              timer_irq_o;
  logic              ipi_o;

  int unsigned                   n_checks;
  int unsigned                   n_errors;
  logic [soc_pkg::DataWidth-1:0] ram_model [soc_pkg::RamWords];

  soc_harness soc_harness_i (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .host_req_i  ( host_req    ),
    .dbg_req_i   ( dbg_req     ),
    .host_rsp_o  ( host_rsp    ),
    .dbg_rsp_o   ( dbg_rsp     ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Run stopped by the watchdog after %0d cycles", WatchdogCycles);
    $display("Verification failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic drive_port(input logic use_dbg, input soc_pkg::bus_req_t req);
    if (use_dbg) begin
      dbg_req = req;
    end else begin
      host_req = req;
    end
  endtask

  function automatic soc_pkg::bus_rsp_t port_rsp(input logic use_dbg);
    return use_dbg ? dbg_rsp : host_rsp;
  endfunction

  // One access on one port; waits for gnt, then takes the response a cycle later
  task automatic bus_xfer(input logic use_dbg, input logic we,
                          input logic [soc_pkg::AddrWidth-1:0] addr,
                          input logic [soc_pkg::BeWidth-1:0] be,
                          input logic [soc_pkg::DataWidth-1:0] wdata,
                          output logic [soc_pkg::DataWidth-1:0] rdata, output logic err);
    soc_pkg::bus_req_t req;
    soc_pkg::bus_rsp_t rsp;
    int unsigned       waited;
    req.req   = 1'b1;
    req.we    = we;
    req.addr  = addr;
    req.be    = be;
    req.wdata = wdata;
    waited    = 0;
    @(negedge clk_i);
    drive_port(use_dbg, req);
    #1;
    rsp = port_rsp(use_dbg);
    while (!rsp.gnt && waited < GntTimeout) begin
      @(negedge clk_i);
      #1;
      rsp = port_rsp(use_dbg);
      waited++;
    end
    n_checks++;
    assert (rsp.gnt) else begin
      n_errors++;
      $display("No grant within %0d cycles for address %h at %0t", GntTimeout, addr, $time);
    end
    @(negedge clk_i);
    rsp = port_rsp(use_dbg);
    n_checks++;
    assert (rsp.r_valid) else begin
      n_errors++;
      $display("No response one cycle after the grant for address %h at %0t", addr, $time);
    end
    drive_port(use_dbg, '0);
    rdata = rsp.rdata;
    err   = rsp.err;
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic reset_state();
    check_value("host gnt after reset", 64'(host_rsp.gnt), 64'd0);
    check_value("debug gnt after reset", 64'(dbg_rsp.gnt), 64'd0);
    check_value("host r_valid after reset", 64'(host_rsp.r_valid), 64'd0);
    check_value("debug r_valid after reset", 64'(dbg_rsp.r_valid), 64'd0);
    check_value("timer_irq_o after reset", 64'(timer_irq_o), 64'd0);
    check_value("ipi_o after reset", 64'(ipi_o), 64'd0);
    check_value("debug_req_o after reset", 64'(debug_req_o), 64'd0);
  endtask

  // Starts on the falling edge where reset is released
  task automatic debug_gate_window();
    int unsigned low_cycles;
    low_cycles = 0;
    while (!debug_req_o && low_cycles <= soc_pkg::DebugDelayCycles) begin
      @(negedge clk_i);
      low_cycles++;
    end
    check_value("debug window cycles", 64'(low_cycles), 64'(soc_pkg::DebugDelayCycles));
    check_value("debug_req_o after window", 64'(debug_req_o), 64'd1);
    debug_en_i = 1'b0;
    #1;
    check_value("debug_req_o while disabled", 64'(debug_req_o), 64'd0);
    @(negedge clk_i);
    debug_en_i = 1'b1;
    #1;
    check_value("debug_req_o enabled again", 64'(debug_req_o), 64'd1);
  endtask

  task automatic rom_reads();
    logic [soc_pkg::DataWidth-1:0] rdata;
    logic                          err;
    for (int i = 0; i < soc_pkg::RomWords; i++) begin
      bus_xfer(1'b0, 1'b0, soc_pkg::RomBase + 32'(i * soc_pkg::BeWidth), '1, '0, rdata, err);
      check_value($sformatf("rom word %0d", i), rdata, soc_pkg::RomImage[i]);
      check_value("rom read err", 64'(err), 64'd0);
    end
    bus_xfer(1'b0, 1'b0, soc_pkg::RomBase + 32'(soc_pkg::RomWords * soc_pkg::BeWidth), '1, '0,
             rdata, err);
    check_value("rom read past image", rdata, 64'd0);
    check_value("rom read past image err", 64'(err), 64'd0);
    bus_xfer(1'b0, 1'b1, soc_pkg::RomBase, '1, 64'h1234_5678, rdata, err);
    check_value("rom write err", 64'(err), 64'd1);
    check_value("rom write rdata", rdata, 64'd0);
  endtask

  task automatic ram_byte_writes();
    logic [soc_pkg::DataWidth-1:0] rdata;
    logic [soc_pkg::DataWidth-1:0] wdata;
    logic [soc_pkg::DataWidth-1:0] mask;
    logic [soc_pkg::AddrWidth-1:0] addr;
    logic [soc_pkg::BeWidth-1:0]   be;
    logic                          err;
    logic                          use_dbg;
    int unsigned                   idx;
    for (int t = 0; t < RamTrials; t++) begin
      idx     = $urandom % soc_pkg::RamWords;
      addr    = soc_pkg::RamBase + 32'(idx * soc_pkg::BeWidth);
      use_dbg = 1'(t % 2);
      wdata   = {$urandom, $urandom};
      bus_xfer(use_dbg, 1'b1, addr, '1, wdata, rdata, err);
      ram_model[idx] = wdata;
      check_value("ram write rdata", rdata, 64'd0);
      check_value("ram write err", 64'(err), 64'd0);
      // Partial write over the known word
      wdata = {$urandom, $urandom};
      be    = 8'($urandom);
      bus_xfer(use_dbg, 1'b1, addr, be, wdata, rdata, err);
      for (int b = 0; b < soc_pkg::BeWidth; b++) begin
        mask[b*8 +: 8] = {8{be[b]}};
      end
      ram_model[idx] = (ram_model[idx] & ~mask) | (wdata & mask);
      bus_xfer(use_dbg, 1'b0, addr, '1, '0, rdata, err);
      check_value($sformatf("ram word %0d be %h", idx, be), rdata, ram_model[idx]);
      check_value("ram read err", 64'(err), 64'd0);
    end
  endtask

  task automatic arbitration_order();
    soc_pkg::bus_req_t hreq;
    soc_pkg::bus_req_t dreq;
    hreq      = '0;
    hreq.req  = 1'b1;
    hreq.addr = soc_pkg::RomBase + 32'(5 * soc_pkg::BeWidth);
    hreq.be   = '1;
    dreq      = hreq;
    dreq.addr = soc_pkg::RomBase + 32'(2 * soc_pkg::BeWidth);
    @(negedge clk_i);
    host_req = hreq;
    dbg_req  = dreq;
    #1;
    check_value("debug gnt when both request", 64'(dbg_rsp.gnt), 64'd1);
    check_value("host gnt when both request", 64'(host_rsp.gnt), 64'd0);
    @(negedge clk_i);
    check_value("debug r_valid", 64'(dbg_rsp.r_valid), 64'd1);
    check_value("debug rdata", dbg_rsp.rdata, soc_pkg::RomImage[2]);
    check_value("host r_valid during debug response", 64'(host_rsp.r_valid), 64'd0);
    dbg_req = '0;
    #1;
    check_value("host gnt in the next cycle", 64'(host_rsp.gnt), 64'd1);
    @(negedge clk_i);
    check_value("host r_valid", 64'(host_rsp.r_valid), 64'd1);
    check_value("host rdata", host_rsp.rdata, soc_pkg::RomImage[5]);
    check_value("debug r_valid during host response", 64'(dbg_rsp.r_valid), 64'd0);
    host_req = '0;
  endtask

  task automatic unmapped_error();
    logic [soc_pkg::DataWidth-1:0] rdata;
    logic                          err;
    bus_xfer(1'b0, 1'b0, 32'h4000_0000, '1, '0, rdata, err);
    check_value("unmapped read err", 64'(err), 64'd1);
    check_value("unmapped read rdata", rdata, 64'd0);
    bus_xfer(1'b1, 1'b1, 32'h0000_0100, '1, 64'hffff, rdata, err);
    check_value("unmapped write err", 64'(err), 64'd1);
    check_value("unmapped write rdata", rdata, 64'd0);
  endtask

  task automatic timer_interrupts();
    logic [soc_pkg::DataWidth-1:0] rdata;
    logic                          err;
    bus_xfer(1'b0, 1'b1, soc_pkg::ClintBase + 32'(soc_pkg::MtimeOffset), '1, '0, rdata, err);
    bus_xfer(1'b0, 1'b1, soc_pkg::ClintBase + 32'(soc_pkg::MtimecmpOffset), '1, 64'd5,
             rdata, err);
    check_value("timer_irq_o before pulses", 64'(timer_irq_o), 64'd0);
    for (int k = 1; k <= 5; k++) begin
      @(negedge clk_i);
      rtc_i = 1'b1;
      @(negedge clk_i);
      rtc_i = 1'b0;
      check_value($sformatf("timer_irq_o after pulse %0d", k), 64'(timer_irq_o), 64'(k >= 5));
    end
    bus_xfer(1'b0, 1'b0, soc_pkg::ClintBase + 32'(soc_pkg::MtimeOffset), '1, '0, rdata, err);
    check_value("mtime after pulses", rdata, 64'd5);
    bus_xfer(1'b0, 1'b1, soc_pkg::ClintBase + 32'(soc_pkg::MtimecmpOffset), '1, 64'd100,
             rdata, err);
    check_value("timer_irq_o after larger mtimecmp", 64'(timer_irq_o), 64'd0);
    bus_xfer(1'b1, 1'b1, soc_pkg::ClintBase + 32'(soc_pkg::MsipOffset), '1, 64'd1, rdata, err);
    check_value("ipi_o after msip set", 64'(ipi_o), 64'd1);
    bus_xfer(1'b1, 1'b1, soc_pkg::ClintBase + 32'(soc_pkg::MsipOffset), '1, 64'd0, rdata, err);
    check_value("ipi_o after msip clear", 64'(ipi_o), 64'd0);
  endtask

  // --------------------------------------------------------------------------
  // Sequence
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(2682));
    n_checks    = 0;
    n_errors    = 0;
    rst_ni      = 1'b0;
    rtc_i       = 1'b0;
    host_req    = '0;
    dbg_req     = '0;
    debug_req_i = 1'b1;
    debug_en_i  = 1'b1;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    reset_state();
    debug_gate_window();
    rom_reads();
    ram_byte_writes();
    arbitration_order();
    unmapped_error();
    timer_interrupts();
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
common/soc_pkg.sv
rtl/bus_arbiter.sv
rtl/addr_decoder.sv
rtl/boot_rom.sv
rtl/sram.sv
rtl/clint_timer.sv
rtl/debug_req_gate.sv
rtl/soc_harness.sv
tests/soc_harness_sva.sv
tests/tb_soc_harness.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc_harness -Mdir build -f list.f

./build/Vtb_soc_harness | tee sim.log

if grep -q "Verification passed" sim.log; then
  exit 0
fi
exit 1
